//--- all.f
+incdir+include
hw/tracker_pkg.sv
hw/chroma_convert.sv
hw/chroma_threshold.sv
hw/centroid_accum.sv
hw/serial_divider.sv
hw/tracker_ctrl.sv
hw/tracker_regs.sv
hw/color_tracker_top.sv
testbench/tb_video_source.sv
testbench/tb_color_tracker.sv

//--- hw/centroid_accum.sv
module centroid_accum (
  input  logic                      clk_pixel,
  input  logic                      sys_rst_pixel,
  input  tracker_pkg::mask_beat_t   beat_i,
  input  logic                      hit_i,
  output tracker_pkg::frame_sums_t  sums_o,
  output logic                      sums_valid_o
);

  import tracker_pkg::*;

  // running totals for the frame in progress
  frame_sums_t run;
  // totals including the current beat
  frame_sums_t next;
  logic take;

  assign take = beat_i.valid && hit_i;

  always_comb
  begin
    next = run;
    if (take)
    begin
      next.sum_x = run.sum_x + sum_t'(beat_i.hcount);
      next.sum_y = run.sum_y + sum_t'(beat_i.vcount);
      next.count = run.count + count_t'(1);
    end
  end

  always_ff @(posedge clk_pixel)
  begin
    if (sys_rst_pixel)
    begin
      run <= '0;
      sums_valid_o <= 1'b0;
    end
    else
    begin
      // one cycle pulse right after the last pixel of a frame
      sums_valid_o <= beat_i.valid && beat_i.eof;
      if (beat_i.valid && beat_i.eof)
        run <= '0;
      else
        run <= next;
    end
  end

  // snapshot holds until the next frame ends
  always_ff @(posedge clk_pixel)
  begin
    if (beat_i.valid && beat_i.eof)
      sums_o <= next;
  end

  // a frame larger than the counter would corrupt the averages
  a_count_no_wrap: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    take |-> run.count != '1);

endmodule

//--- hw/chroma_convert.sv
module chroma_convert (
  input  logic                       clk_pixel,
  input  logic                       sys_rst_pixel,
  input  tracker_pkg::pixel_beat_t   pix_i,
  output tracker_pkg::chroma_beat_t  chroma_o
);

  import tracker_pkg::*;

  // 565 fields widened to 8 bits, low bits zero
  chan_t r8, g8, b8;

  // stage 1: unsigned products of each coefficient
  logic [14:0] cr_r_p, cr_g_p, cr_b_p;
  logic [14:0] cb_r_p, cb_g_p, cb_b_p;
  logic s1_valid, s1_eof;
  coord_x_t s1_x;
  coord_y_t s1_y;

  // stage 2: signed sums with the rounding constant
  logic signed [16:0] cr_sum, cb_sum;
  logic s2_valid, s2_eof;
  coord_x_t s2_x;
  coord_y_t s2_y;

  // scale back by 256, recenter on 128 and saturate to a byte
  function automatic chan_t clamp_chan(input logic signed [16:0] sum);
    logic signed [16:0] v;
    v = (sum >>> 8) + 17'sd128;
    if (v < 17'sd0)
      return '0;
    else if (v > 17'sd255)
      return 8'hFF;
    else
      return v[7:0];
  endfunction

  assign r8 = {pix_i.rgb565[15:11], 3'b000};
  assign g8 = {pix_i.rgb565[10:5], 2'b00};
  assign b8 = {pix_i.rgb565[4:0], 3'b000};

  always_ff @(posedge clk_pixel)
  begin
    // products carry no reset, only valid does
    cr_r_p <= 15'(r8) * 15'd112;
    cr_g_p <= 15'(g8) * 15'd94;
    cr_b_p <= 15'(b8) * 15'd18;
    cb_r_p <= 15'(r8) * 15'd38;
    cb_g_p <= 15'(g8) * 15'd74;
    cb_b_p <= 15'(b8) * 15'd112;
    s1_eof <= pix_i.eof;
    s1_x <= pix_i.hcount;
    s1_y <= pix_i.vcount;

    // cr = 112r - 94g - 18b, cb = 112b - 38r - 74g
    cr_sum <= $signed({2'b00, cr_r_p}) - $signed({2'b00, cr_g_p})
              - $signed({2'b00, cr_b_p}) + 17'sd128;
    cb_sum <= $signed({2'b00, cb_b_p}) - $signed({2'b00, cb_r_p})
              - $signed({2'b00, cb_g_p}) + 17'sd128;
    s2_eof <= s1_eof;
    s2_x <= s1_x;
    s2_y <= s1_y;

    // stage 3 drives the output beat
    chroma_o.cr <= clamp_chan(cr_sum);
    chroma_o.cb <= clamp_chan(cb_sum);
    chroma_o.eof <= s2_eof;
    chroma_o.hcount <= s2_x;
    chroma_o.vcount <= s2_y;

    if (sys_rst_pixel)
    begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      chroma_o.valid <= 1'b0;
    end
    else
    begin
      s1_valid <= pix_i.valid;
      s2_valid <= s1_valid;
      chroma_o.valid <= s2_valid;
    end
  end

endmodule

//--- hw/chroma_threshold.sv
module chroma_threshold (
  input  logic                       clk_pixel,
  input  logic                       sys_rst_pixel,
  input  tracker_pkg::chroma_beat_t  chroma_i,
  input  tracker_pkg::thresh_t       thresh_cr_i,
  input  tracker_pkg::thresh_t       thresh_cb_i,
  output tracker_pkg::mask_beat_t    mask_o
);

  import tracker_pkg::*;

  // window compares, both bounds inclusive
  logic in_cr, in_cb;

  assign in_cr = (chroma_i.cr >= thresh_cr_i.lower) && (chroma_i.cr <= thresh_cr_i.upper);
  assign in_cb = (chroma_i.cb >= thresh_cb_i.lower) && (chroma_i.cb <= thresh_cb_i.upper);

  always_ff @(posedge clk_pixel)
  begin
    // target A follows cr, target B follows cb
    mask_o.hit_a <= in_cr;
    mask_o.hit_b <= in_cb;
    mask_o.eof <= chroma_i.eof;
    mask_o.hcount <= chroma_i.hcount;
    mask_o.vcount <= chroma_i.vcount;
    if (sys_rst_pixel)
      mask_o.valid <= 1'b0;
    else
      mask_o.valid <= chroma_i.valid;
  end

endmodule

//--- hw/color_tracker_top.sv
`include "tracker_consts.svh"

module color_tracker_top (
  input  logic                     clk_pixel,
  input  logic                     sys_rst_pixel,
  input  tracker_pkg::pixel_beat_t pix_i,
  input  logic                     apb_psel_i,
  input  logic                     apb_penable_i,
  input  logic                     apb_pwrite_i,
  input  logic [`APB_ADDR_W-1:0]   apb_paddr_i,
  input  logic [`APB_DATA_W-1:0]   apb_pwdata_i,
  output logic [`APB_DATA_W-1:0]   apb_prdata_o,
  output logic                     apb_pready_o,
  output logic                     apb_pslverr_o
);

  import tracker_pkg::*;

  chroma_beat_t chroma;
  mask_beat_t mask;
  thresh_t thresh_cr, thresh_cb;
  frame_sums_t sums_a, sums_b;
  logic sums_valid_a;
  logic div_start, div_done;
  sum_t dividend, quotient;
  count_t divisor;
  centroid_t centroid_a, centroid_b;
  logic publish;

  // 3 cycle color conversion
  chroma_convert u_convert (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .pix_i         (pix_i),
    .chroma_o      (chroma)
  );

  chroma_threshold u_threshold (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .chroma_i      (chroma),
    .thresh_cr_i   (thresh_cr),
    .thresh_cb_i   (thresh_cb),
    .mask_o        (mask)
  );

  // target A tracks the cr mask
  centroid_accum u_accum_a (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .beat_i        (mask),
    .hit_i         (mask.hit_a),
    .sums_o        (sums_a),
    .sums_valid_o  (sums_valid_a)
  );

  // target B tracks the cb mask, its pulse matches the A pulse
  centroid_accum u_accum_b (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .beat_i        (mask),
    .hit_i         (mask.hit_b),
    .sums_o        (sums_b),
    .sums_valid_o  ()
  );

  // one divider shared by all four averages
  serial_divider u_divider (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .start_i       (div_start),
    .dividend_i    (dividend),
    .divisor_i     (divisor),
    .quotient_o    (quotient),
    .done_o        (div_done)
  );

  // the A pulse stands for both accumulators
  tracker_ctrl u_ctrl (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .sums_a_i      (sums_a),
    .sums_b_i      (sums_b),
    .sums_valid_i  (sums_valid_a),
    .quotient_i    (quotient),
    .div_done_i    (div_done),
    .div_start_o   (div_start),
    .dividend_o    (dividend),
    .divisor_o     (divisor),
    .centroid_a_o  (centroid_a),
    .centroid_b_o  (centroid_b),
    .publish_o     (publish)
  );

  tracker_regs u_regs (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .apb_psel_i    (apb_psel_i),
    .apb_penable_i (apb_penable_i),
    .apb_pwrite_i  (apb_pwrite_i),
    .apb_paddr_i   (apb_paddr_i),
    .apb_pwdata_i  (apb_pwdata_i),
    .centroid_a_i  (centroid_a),
    .centroid_b_i  (centroid_b),
    .publish_i     (publish),
    .apb_prdata_o  (apb_prdata_o),
    .apb_pready_o  (apb_pready_o),
    .apb_pslverr_o (apb_pslverr_o),
    .thresh_cr_o   (thresh_cr),
    .thresh_cb_o   (thresh_cb)
  );

endmodule

//--- hw/serial_divider.sv
module serial_divider (
  input  logic                clk_pixel,
  input  logic                sys_rst_pixel,
  input  logic                start_i,
  input  tracker_pkg::sum_t   dividend_i,
  input  tracker_pkg::count_t divisor_i,
  output tracker_pkg::sum_t   quotient_o,
  output logic                done_o
);

  import tracker_pkg::*;

  logic busy;
  // one step per quotient bit, 32 in all
  logic [4:0] step;

  // dividend shifts out of the top while quotient bits shift in
  sum_t quo_r;
  count_t rem_r;
  count_t div_r;

  // partial remainder with the next dividend bit appended
  logic [$bits(count_t):0] shifted;
  logic [$bits(count_t):0] diff;
  logic fits;

  assign shifted = {rem_r, quo_r[$bits(sum_t)-1]};
  assign diff = shifted - {1'b0, div_r};
  // restore when the trial subtract would go negative
  assign fits = shifted >= {1'b0, div_r};
  assign quotient_o = quo_r;

  always_ff @(posedge clk_pixel)
  begin
    if (sys_rst_pixel)
    begin
      busy <= 1'b0;
      step <= '0;
      done_o <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      if (start_i)
      begin
        busy <= 1'b1;
        step <= '0;
      end
      else if (busy)
      begin
        step <= step + 5'd1;
        // last step lands done exactly 33 cycles after start
        if (step == 5'd31)
        begin
          busy <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_pixel)
  begin
    if (start_i)
    begin
      quo_r <= dividend_i;
      rem_r <= '0;
      div_r <= divisor_i;
    end
    else if (busy)
    begin
      quo_r <= {quo_r[$bits(sum_t)-2:0], fits};
      rem_r <= fits ? count_t'(diff) : count_t'(shifted);
    end
  end

  // the controller must wait for done and skip empty targets
  a_start_legal: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    start_i |-> !busy && (divisor_i != '0));

endmodule

//--- hw/tracker_ctrl.sv
module tracker_ctrl (
  input  logic                      clk_pixel,
  input  logic                      sys_rst_pixel,
  input  tracker_pkg::frame_sums_t  sums_a_i,
  input  tracker_pkg::frame_sums_t  sums_b_i,
  input  logic                      sums_valid_i,
  input  tracker_pkg::sum_t         quotient_i,
  input  logic                      div_done_i,
  output logic                      div_start_o,
  output tracker_pkg::sum_t         dividend_o,
  output tracker_pkg::count_t       divisor_o,
  output tracker_pkg::centroid_t    centroid_a_o,
  output tracker_pkg::centroid_t    centroid_b_o,
  output logic                      publish_o
);

  import tracker_pkg::*;

  ctrl_state_t state;
  // frame totals held while the divider works through them
  frame_sums_t sums_a_r, sums_b_r;
  // centroids under construction, copied out at publish
  centroid_t work_a, work_b;
  logic on_b;

  assign on_b = (state == CTRL_DIV_BX) || (state == CTRL_DIV_BY);
  assign divisor_o = on_b ? sums_b_r.count : sums_a_r.count;

  // divider samples its operands only on the start pulse
  always_comb
  begin
    case (state)
      CTRL_DIV_AX: dividend_o = sums_a_r.sum_x;
      CTRL_DIV_AY: dividend_o = sums_a_r.sum_y;
      CTRL_DIV_BX: dividend_o = sums_b_r.sum_x;
      default:     dividend_o = sums_b_r.sum_y;
    endcase
  end

  always_ff @(posedge clk_pixel)
  begin
    if (sys_rst_pixel)
    begin
      state <= CTRL_IDLE;
      div_start_o <= 1'b0;
      publish_o <= 1'b0;
      centroid_a_o <= '0;
      centroid_b_o <= '0;
    end
    else
    begin
      div_start_o <= 1'b0;
      publish_o <= 1'b0;
      case (state)
        CTRL_IDLE:
          // sums arriving in any other state are dropped
          if (sums_valid_i)
          begin
            sums_a_r <= sums_a_i;
            sums_b_r <= sums_b_i;
            // an empty target keeps its old coordinates
            work_a <= '{found: sums_a_i.count != '0, x: centroid_a_o.x, y: centroid_a_o.y};
            work_b <= '{found: sums_b_i.count != '0, x: centroid_b_o.x, y: centroid_b_o.y};
            if (sums_a_i.count != '0)
            begin
              state <= CTRL_DIV_AX;
              div_start_o <= 1'b1;
            end
            else if (sums_b_i.count != '0)
            begin
              state <= CTRL_DIV_BX;
              div_start_o <= 1'b1;
            end
            else
              state <= CTRL_PUBLISH;
          end
        CTRL_DIV_AX:
          if (div_done_i)
          begin
            work_a.x <= coord_x_t'(quotient_i);
            state <= CTRL_DIV_AY;
            div_start_o <= 1'b1;
          end
        CTRL_DIV_AY:
          if (div_done_i)
          begin
            work_a.y <= coord_y_t'(quotient_i);
            if (sums_b_r.count != '0)
            begin
              state <= CTRL_DIV_BX;
              div_start_o <= 1'b1;
            end
            else
              state <= CTRL_PUBLISH;
          end
        CTRL_DIV_BX:
          if (div_done_i)
          begin
            work_b.x <= coord_x_t'(quotient_i);
            state <= CTRL_DIV_BY;
            div_start_o <= 1'b1;
          end
        CTRL_DIV_BY:
          if (div_done_i)
          begin
            work_b.y <= coord_y_t'(quotient_i);
            state <= CTRL_PUBLISH;
          end
        CTRL_PUBLISH:
        begin
          // both targets change together with the pulse
          centroid_a_o <= work_a;
          centroid_b_o <= work_b;
          publish_o <= 1'b1;
          state <= CTRL_IDLE;
        end
        default:
          state <= CTRL_IDLE;
      endcase
    end
  end

endmodule

//--- hw/tracker_pkg.sv
package tracker_pkg;

  `include "tracker_consts.svh"

  // plain vectors with a meaning of their own
  typedef logic [`COORD_X_W-1:0] coord_x_t;
  typedef logic [`COORD_Y_W-1:0] coord_y_t;
  typedef logic [`CHAN_W-1:0] chan_t;
  typedef logic [`SUM_W-1:0] sum_t;
  typedef logic [`COUNT_W-1:0] count_t;
  // r in 15:11, g in 10:5, b in 4:0
  typedef logic [15:0] rgb565_t;

  // raw pixel as it arrives from the source
  typedef struct packed {
    logic valid;
    logic eof;
    coord_x_t hcount;
    coord_y_t vcount;
    rgb565_t rgb565;
  } pixel_beat_t;

  // same beat after color conversion
  typedef struct packed {
    logic valid;
    logic eof;
    coord_x_t hcount;
    coord_y_t vcount;
    chan_t cr;
    chan_t cb;
  } chroma_beat_t;

  // same beat after thresholding, one hit bit per target
  typedef struct packed {
    logic valid;
    logic eof;
    coord_x_t hcount;
    coord_y_t vcount;
    logic hit_a;
    logic hit_b;
  } mask_beat_t;

  // inclusive window on one channel
  typedef struct packed {
    chan_t lower;
    chan_t upper;
  } thresh_t;

  // totals of one target over one frame
  typedef struct packed {
    sum_t sum_x;
    sum_t sum_y;
    count_t count;
  } frame_sums_t;

  // published center of mass
  typedef struct packed {
    logic found;
    coord_x_t x;
    coord_y_t y;
  } centroid_t;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_DIV_AX,
    CTRL_DIV_AY,
    CTRL_DIV_BX,
    CTRL_DIV_BY,
    CTRL_PUBLISH
  } ctrl_state_t;

endpackage

//--- hw/tracker_regs.sv
`include "tracker_consts.svh"

module tracker_regs (
  input  logic                     clk_pixel,
  input  logic                     sys_rst_pixel,
  input  logic                     apb_psel_i,
  input  logic                     apb_penable_i,
  input  logic                     apb_pwrite_i,
  input  logic [`APB_ADDR_W-1:0]   apb_paddr_i,
  input  logic [`APB_DATA_W-1:0]   apb_pwdata_i,
  input  tracker_pkg::centroid_t   centroid_a_i,
  input  tracker_pkg::centroid_t   centroid_b_i,
  input  logic                     publish_i,
  output logic [`APB_DATA_W-1:0]   apb_prdata_o,
  output logic                     apb_pready_o,
  output logic                     apb_pslverr_o,
  output tracker_pkg::thresh_t     thresh_cr_o,
  output tracker_pkg::thresh_t     thresh_cb_o
);

  import tracker_pkg::*;

  // access phase of an APB transfer
  logic access;
  logic mapped, writable, err;
  logic [`APB_DATA_W-1:0] rdata;
  logic [15:0] frame_count;

  // centroid word: found in 31, y in 25:16, x in 10:0
  function automatic logic [`APB_DATA_W-1:0] pack_centroid(input centroid_t c);
    return {c.found, 5'b0, c.y, 5'b0, c.x};
  endfunction

  assign access = apb_psel_i && apb_penable_i;
  assign apb_pready_o = 1'b1;

  always_comb
  begin
    mapped = 1'b1;
    writable = 1'b0;
    rdata = '0;
    case (apb_paddr_i)
      `REG_THRESH_CR:
      begin
        writable = 1'b1;
        rdata = {16'b0, thresh_cr_o.upper, thresh_cr_o.lower};
      end
      `REG_THRESH_CB:
      begin
        writable = 1'b1;
        rdata = {16'b0, thresh_cb_o.upper, thresh_cb_o.lower};
      end
      `REG_CENTROID_A: rdata = pack_centroid(centroid_a_i);
      `REG_CENTROID_B: rdata = pack_centroid(centroid_b_i);
      `REG_STATUS:     rdata = {16'b0, frame_count};
      default:         mapped = 1'b0;
    endcase
  end

  // unmapped, or a write to a read-only word
  assign err = !mapped || (apb_pwrite_i && !writable);
  assign apb_pslverr_o = access && err;
  assign apb_prdata_o = err ? '0 : rdata;

  always_ff @(posedge clk_pixel)
  begin
    if (sys_rst_pixel)
    begin
      thresh_cr_o <= '{lower: `THRESH_LOWER_RST, upper: `THRESH_UPPER_RST};
      thresh_cb_o <= '{lower: `THRESH_LOWER_RST, upper: `THRESH_UPPER_RST};
      frame_count <= '0;
    end
    else
    begin
      if (publish_i)
        frame_count <= frame_count + 16'd1;
      // erroring writes leave every register alone
      if (access && apb_pwrite_i && !err)
      begin
        if (apb_paddr_i == `REG_THRESH_CR)
          thresh_cr_o <= '{lower: apb_pwdata_i[7:0], upper: apb_pwdata_i[15:8]};
        else
          thresh_cb_o <= '{lower: apb_pwdata_i[7:0], upper: apb_pwdata_i[15:8]};
      end
    end
  end

  // every access phase must follow a setup with psel held
  a_penable_needs_psel: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    apb_penable_i |-> apb_psel_i);

endmodule

//--- include/tracker_consts.svh
`ifndef TRACKER_CONSTS_SVH
`define TRACKER_CONSTS_SVH

// pixel coordinate widths, enough for a 1280x720 raster
`define COORD_X_W 11
`define COORD_Y_W 10

// one 8-bit color or chroma channel
`define CHAN_W 8

// per-frame accumulator widths
`define SUM_W 32
`define COUNT_W 21

// APB bus widths
`define APB_ADDR_W 8
`define APB_DATA_W 32

// register map, byte offsets
`define REG_THRESH_CR 8'h00
`define REG_THRESH_CB 8'h04
`define REG_CENTROID_A 8'h08
`define REG_CENTROID_B 8'h0C
`define REG_STATUS 8'h10

// threshold window after reset
`define THRESH_LOWER_RST 8'hA0
`define THRESH_UPPER_RST 8'hF0

`endif

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --timescale 1ns/1ps \
       -f all.f --top-module tb_color_tracker -o sim_tb \
  && ./obj_dir/sim_tb \
  || exit 1

//--- testbench/tb_color_tracker.sv
`include "tracker_consts.svh"

module tb_color_tracker;

  timeunit 1ns;
  timeprecision 1ps;

  import tracker_pkg::*;

  localparam int FRAMES = 6;
  // one 64x48 frame plus pipeline slack
  localparam int FRAME_TIMEOUT = 4000;
  localparam int POLL_TIMEOUT = 200;

  // picture, windows, and which targets the frame must find
  typedef struct packed {
    rgb565_t bg;
    rgb565_t fg;
    coord_x_t x0;
    coord_x_t x1;
    coord_y_t y0;
    coord_y_t y1;
    thresh_t thr_cr;
    thresh_t thr_cb;
    logic noise;
    logic found_a;
    logic found_b;
  } frame_row_t;

  logic clk_pixel;
  logic sys_rst_pixel;
  pixel_beat_t pix;
  logic apb_psel;
  logic apb_penable;
  logic apb_pwrite;
  logic [`APB_ADDR_W-1:0] apb_paddr;
  logic [`APB_DATA_W-1:0] apb_pwdata;
  logic [`APB_DATA_W-1:0] apb_prdata;
  logic apb_pready;
  logic apb_pslverr;
  logic src_start;
  logic src_done;
  frame_row_t rows [FRAMES];
  frame_row_t cur_row;

  // model totals, index 0 is target A on Cr, index 1 is target B on Cb
  int run_sx [2];
  int run_sy [2];
  int run_n [2];
  int tot_sx [2];
  int tot_sy [2];
  int tot_n [2];

  color_tracker_top UUT (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .pix_i         (pix),
    .apb_psel_i    (apb_psel),
    .apb_penable_i (apb_penable),
    .apb_pwrite_i  (apb_pwrite),
    .apb_paddr_i   (apb_paddr),
    .apb_pwdata_i  (apb_pwdata),
    .apb_prdata_o  (apb_prdata),
    .apb_pready_o  (apb_pready),
    .apb_pslverr_o (apb_pslverr)
  );

  tb_video_source u_source (
    .clk_pixel    (clk_pixel),
    .start_i      (src_start),
    .noise_i      (cur_row.noise),
    .bg_i         (cur_row.bg),
    .rect_color_i (cur_row.fg),
    .rect_x0_i    (cur_row.x0),
    .rect_x1_i    (cur_row.x1),
    .rect_y0_i    (cur_row.y0),
    .rect_y1_i    (cur_row.y1),
    .pix_o        (pix),
    .done_o       (src_done)
  );

  // 125 MHz pixel clock
  always #4 clk_pixel = ~clk_pixel;

  // widen 565 to bytes, weight, round, divide by 256, recenter, saturate
  function automatic int chroma_of(input int kr, input int kg, input int kb, input rgb565_t c);
    int r;
    int g;
    int b;
    int v;
    r = int'(c[15:11]) << 3;
    g = int'(c[10:5]) << 2;
    b = int'(c[4:0]) << 3;
    v = ((kr * r + kg * g + kb * b + 128) >>> 8) + 128;
    if (v < 0)
      v = 0;
    else if (v > 255)
      v = 255;
    return v;
  endfunction

  function automatic logic in_window(input int v, input thresh_t t);
    return (v >= int'(t.lower)) && (v <= int'(t.upper));
  endfunction

  // register layouts
  function automatic logic [31:0] thresh_word(input thresh_t t);
    return {16'b0, t.upper, t.lower};
  endfunction

  function automatic logic [31:0] centroid_word(input logic found, input int x, input int y);
    return {found, 5'b0, coord_y_t'(y), 5'b0, coord_x_t'(x)};
  endfunction

  function automatic frame_row_t make_row(input rgb565_t bg, input rgb565_t fg,
      input coord_x_t x0, input coord_x_t x1, input coord_y_t y0, input coord_y_t y1,
      input thresh_t cr, input thresh_t cb, input logic noise, input logic fa, input logic fb);
    return {bg, fg, x0, x1, y0, y1, cr, cb, noise, fa, fb};
  endfunction

  // reference model watches the driven beats and applies the window rules
  always @(posedge clk_pixel)
  begin
    logic [1:0] hit;
    if (pix.valid)
    begin
      hit[0] = in_window(chroma_of(112, -94, -18, pix.rgb565), cur_row.thr_cr);
      hit[1] = in_window(chroma_of(-38, -74, 112, pix.rgb565), cur_row.thr_cb);
      for (int t = 0; t < 2; t++)
      begin
        if (hit[t])
        begin
          run_sx[t] += int'(pix.hcount);
          run_sy[t] += int'(pix.vcount);
          run_n[t] += 1;
        end
        // eof beat counts too, then the totals freeze for the checks
        if (pix.eof)
        begin
          tot_sx[t] = run_sx[t];
          tot_sy[t] = run_sy[t];
          tot_n[t] = run_n[t];
          run_sx[t] = 0;
          run_sy[t] = 0;
          run_n[t] = 0;
        end
      end
    end
  end

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Finished with errors");
    $fatal(1, "simulation stopped by a timeout");
  endtask

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first mismatch");
    end
  endtask

  // setup phase, then a single access phase with zero wait states
  task automatic apb_access(input logic write, input logic [`APB_ADDR_W-1:0] addr,
      input logic [`APB_DATA_W-1:0] wdata, output logic [`APB_DATA_W-1:0] rdata,
      output logic err);
    @(posedge clk_pixel);
    #1;
    apb_psel = 1'b1;
    apb_pwrite = write;
    apb_paddr = addr;
    apb_pwdata = wdata;
    @(posedge clk_pixel);
    #1;
    apb_penable = 1'b1;
    // response is settled mid cycle, ahead of the completing edge
    #1;
    expect_equal({31'b0, apb_pready}, 32'd1, "APB pready in the access phase");
    rdata = apb_prdata;
    err = apb_pslverr;
    @(posedge clk_pixel);
    #1;
    apb_psel = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite = 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp,
      input logic exp_err, input string what);
    logic [31:0] rd;
    logic err;
    apb_access(1'b0, addr, 32'd0, rd, err);
    expect_equal({31'b0, err}, {31'b0, exp_err}, {what, " pslverr"});
    expect_equal(rd, exp, what);
  endtask

  task automatic write_check(input logic [7:0] addr, input logic [31:0] data,
      input logic exp_err, input string what);
    logic [31:0] rd;
    logic err;
    apb_access(1'b1, addr, data, rd, err);
    expect_equal({31'b0, err}, {31'b0, exp_err}, {what, " pslverr"});
  endtask

  initial
  begin
    int i;
    int waited;
    logic [31:0] rd;
    logic err;
    logic [15:0] frames_seen;
    int exp_x [2];
    int exp_y [2];
    logic exp_found [2];
    clk_pixel = 1'b0;
    sys_rst_pixel = 1'b1;
    apb_psel = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite = 1'b0;
    apb_paddr = '0;
    apb_pwdata = '0;
    src_start = 1'b0;
    frames_seen = '0;
    for (i = 0; i < 2; i++)
    begin
      exp_x[i] = 0;
      exp_y[i] = 0;
      exp_found[i] = 1'b0;
    end
    // thresholds as {lower, upper}; red Cr 237 Cb 91, blue Cr 111 Cb 237
    rows[0] = make_row(16'h0000, 16'hF800, 11'd10, 11'd29, 10'd5, 10'd20,
                       16'hA0F0, 16'hA0F0, 1'b0, 1'b1, 1'b0);
    // blue only reaches the Cb window
    rows[1] = make_row(16'h0000, 16'h001F, 11'd40, 11'd60, 10'd30, 10'd47,
                       16'hA0F0, 16'hA0F0, 1'b0, 1'b0, 1'b1);
    // red on green, narrow windows that catch red on both channels
    rows[2] = make_row(16'h07E0, 16'hF800, 11'd0, 11'd63, 10'd0, 10'd10,
                       16'hE0FF, 16'h5060, 1'b0, 1'b1, 1'b1);
    // white everywhere sits at 127, outside both windows
    rows[3] = make_row(16'hFFFF, 16'hFFFF, 11'd5, 11'd9, 10'd5, 10'd9,
                       16'hA0F0, 16'hA0F0, 1'b0, 1'b0, 1'b0);
    rows[4] = make_row(16'h0000, 16'h0000, 11'd0, 11'd0, 10'd0, 10'd0,
                       16'h40C0, 16'h30D0, 1'b1, 1'b1, 1'b1);
    rows[5] = make_row(16'h0000, 16'h0000, 11'd0, 11'd0, 10'd0, 10'd0,
                       16'h80FF, 16'h007F, 1'b1, 1'b1, 1'b1);
    cur_row = rows[0];
    repeat (3) @(posedge clk_pixel);
    #1;
    sys_rst_pixel = 1'b0;

    // register state right after reset
    read_check(`REG_THRESH_CR, 32'h0000_F0A0, 1'b0, "Cr threshold after reset");
    read_check(`REG_THRESH_CB, 32'h0000_F0A0, 1'b0, "Cb threshold after reset");
    read_check(`REG_CENTROID_A, 32'd0, 1'b0, "centroid A after reset");
    read_check(`REG_CENTROID_B, 32'd0, 1'b0, "centroid B after reset");
    read_check(`REG_STATUS, 32'd0, 1'b0, "STATUS after reset");

    // read-only and unmapped words flag pslverr and change nothing
    write_check(`REG_CENTROID_A, 32'hFFFF_FFFF, 1'b1, "write to centroid A");
    read_check(`REG_CENTROID_A, 32'd0, 1'b0, "centroid A after bad write");
    write_check(`REG_STATUS, 32'h0000_FFFF, 1'b1, "write to STATUS");
    read_check(`REG_STATUS, 32'd0, 1'b0, "STATUS after bad write");
    read_check(8'h14, 32'd0, 1'b1, "read of unmapped word");
    write_check(8'h20, 32'h0000_1234, 1'b1, "write to unmapped word");
    read_check(`REG_THRESH_CR, 32'h0000_F0A0, 1'b0, "Cr threshold after unmapped write");
    read_check(`REG_THRESH_CB, 32'h0000_F0A0, 1'b0, "Cb threshold after unmapped write");
    write_check(`REG_THRESH_CB, 32'h0000_C350, 1'b0, "Cb threshold write");
    read_check(`REG_THRESH_CB, 32'h0000_C350, 1'b0, "Cb threshold readback");

    for (i = 0; i < FRAMES; i++)
    begin
      cur_row = rows[i];
      write_check(`REG_THRESH_CR, thresh_word(cur_row.thr_cr), 1'b0, "Cr threshold write");
      write_check(`REG_THRESH_CB, thresh_word(cur_row.thr_cb), 1'b0, "Cb threshold write");
      read_check(`REG_THRESH_CR, thresh_word(cur_row.thr_cr), 1'b0, "Cr threshold readback");
      read_check(`REG_THRESH_CB, thresh_word(cur_row.thr_cb), 1'b0, "Cb threshold readback");

      // one cycle start pulse, then wait for the last beat
      @(posedge clk_pixel);
      #1;
      src_start = 1'b1;
      @(posedge clk_pixel);
      #1;
      src_start = 1'b0;
      waited = 0;
      @(posedge clk_pixel);
      while (!src_done)
      begin
        waited++;
        if (waited > FRAME_TIMEOUT)
          stop_on_timeout("the video source to finish a frame");
        @(posedge clk_pixel);
      end

      // publish shows up as a STATUS step
      waited = 0;
      apb_access(1'b0, `REG_STATUS, 32'd0, rd, err);
      while (rd[15:0] == frames_seen)
      begin
        waited++;
        if (waited > POLL_TIMEOUT)
          stop_on_timeout("STATUS to count the frame");
        apb_access(1'b0, `REG_STATUS, 32'd0, rd, err);
      end
      frames_seen++;
      expect_equal(rd, {16'b0, frames_seen}, "STATUS frame count");

      // empty target keeps its old coordinates
      for (int t = 0; t < 2; t++)
      begin
        exp_found[t] = tot_n[t] != 0;
        if (exp_found[t])
        begin
          exp_x[t] = tot_sx[t] / tot_n[t];
          exp_y[t] = tot_sy[t] / tot_n[t];
        end
      end
      apb_access(1'b0, `REG_CENTROID_A, 32'd0, rd, err);
      expect_equal({31'b0, rd[31]}, {31'b0, cur_row.found_a}, "found flag A");
      expect_equal(rd, centroid_word(exp_found[0], exp_x[0], exp_y[0]), "centroid A");
      apb_access(1'b0, `REG_CENTROID_B, 32'd0, rd, err);
      expect_equal({31'b0, rd[31]}, {31'b0, cur_row.found_b}, "found flag B");
      expect_equal(rd, centroid_word(exp_found[1], exp_x[1], exp_y[1]), "centroid B");
      // no second step for the same frame
      read_check(`REG_STATUS, {16'b0, frames_seen}, 1'b0, "STATUS after centroid reads");
    end

    write_check(`REG_CENTROID_B, 32'h1234_5678, 1'b1, "write to centroid B");
    read_check(`REG_CENTROID_B, centroid_word(exp_found[1], exp_x[1], exp_y[1]), 1'b0,
               "centroid B after bad write");
    read_check(`REG_STATUS, FRAMES, 1'b0, "final STATUS");

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- testbench/tb_video_source.sv
module tb_video_source (
  input  logic                     clk_pixel,
  input  logic                     start_i,
  input  logic                     noise_i,
  input  tracker_pkg::rgb565_t     bg_i,
  input  tracker_pkg::rgb565_t     rect_color_i,
  input  tracker_pkg::coord_x_t    rect_x0_i,
  input  tracker_pkg::coord_x_t    rect_x1_i,
  input  tracker_pkg::coord_y_t    rect_y0_i,
  input  tracker_pkg::coord_y_t    rect_y1_i,
  output tracker_pkg::pixel_beat_t pix_o,
  output logic                     done_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import tracker_pkg::*;

  localparam int FRAME_W = 64;
  localparam int FRAME_H = 48;

  // noise state carries over from frame to frame
  logic [31:0] lcg_state;

  // next LCG value, usual 32-bit multiplier and increment
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // rectangle bounds are inclusive on both axes
  function automatic rgb565_t scene_color(input int x, input int y);
    logic inside_x;
    logic inside_y;
    inside_x = (x >= int'(rect_x0_i)) && (x <= int'(rect_x1_i));
    inside_y = (y >= int'(rect_y0_i)) && (y <= int'(rect_y1_i));
    return (inside_x && inside_y) ? rect_color_i : bg_i;
  endfunction

  initial
  begin
    int x;
    int y;
    lcg_state = 32'h1e2a_6afe;
    pix_o = '0;
    done_o = 1'b0;
    forever
    begin
      @(posedge clk_pixel);
      if (start_i)
      begin
        // beats change 1 ns after the edge, back to back, raster order
        #1;
        done_o = 1'b0;
        for (y = 0; y < FRAME_H; y++)
          for (x = 0; x < FRAME_W; x++)
          begin
            pix_o.valid = 1'b1;
            pix_o.eof = (x == FRAME_W - 1) && (y == FRAME_H - 1);
            pix_o.hcount = coord_x_t'(x);
            pix_o.vcount = coord_y_t'(y);
            if (noise_i)
            begin
              // upper half of the state is the better random part
              lcg_state = lcg_next(lcg_state);
              pix_o.rgb565 = lcg_state[31:16];
            end
            else
              pix_o.rgb565 = scene_color(x, y);
            @(posedge clk_pixel);
            #1;
          end
        pix_o = '0;
        done_o = 1'b1;
      end
    end
  end

endmodule
